// ==== Bender.yml ====
package:
  name: soc_misc_ctrl

sources:
  - logic/soc_bus_pkg.sv
  - logic/misc_regs_pkg.sv
  - logic/misc_req_if.sv
  - logic/bus_decode.sv
  - logic/misc_regs.sv
  - logic/flash_select_seq.sv
  - logic/soc_misc_ctrl.sv
  - target: simulation
    files:
      - sim/soc_misc_ctrl_tb.sv

// ==== logic/bus_decode.sv ====
`timescale 1ns/1ps

module bus_decode (
	input  logic                             clk48m,
	input  logic                             rst,
	input  logic                             wb_cyc_i,
	input  logic                             wb_stb_i,
	input  logic                             wb_we_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]    wb_sel_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0]   wb_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0]   wb_dat_i,
	output logic [soc_bus_pkg::DATA_W-1:0]   wb_dat_o,
	output logic                             wb_ack_o,
	output logic                             irq_bus_error_o,
	misc_req_if.decoder                      req
);
	import soc_bus_pkg::*;
	import misc_regs_pkg::*;

	logic              take;
	logic              ack_q;
	bus_region_e       region_q;
	misc_reg_e         idx_q;
	logic              we_q;
	logic [DATA_W-1:0] wdata_q;
	logic              is_misc;

	// ------------------------------------------------------------
	// request capture
	// ------------------------------------------------------------

	// a held stb during the ack cycle is the same request, skip it
	assign take = wb_cyc_i && wb_stb_i && !ack_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= take;
		end
	end

	always_ff @(posedge clk48m) begin
		if (take) begin
			region_q <= bus_region_e'(wb_adr_i[ADDR_W-1 -: $bits(bus_region_e)]);
			idx_q    <= misc_reg_e'(wb_adr_i[2 +: $bits(misc_reg_e)]);
			// only byte lane 0 carries register data
			we_q     <= wb_we_i && wb_sel_i[0];
			wdata_q  <= wb_dat_i;
		end
	end

	// ------------------------------------------------------------
	// response, all in the ack cycle
	// ------------------------------------------------------------

	assign is_misc = (region_q == REGION_MISC);

	assign req.req_valid = ack_q && is_misc;
	assign req.req_we    = we_q;
	assign req.req_idx   = idx_q;
	assign req.req_wdata = wdata_q;

	assign wb_ack_o = ack_q;
	assign wb_dat_o = is_misc ? req.rdata : BUS_ERROR_WORD;

	// unmapped region, one pulse per access
	assign irq_bus_error_o = ack_q && !is_misc;

endmodule

// ==== logic/flash_select_seq.sv ====
`timescale 1ns/1ps

module flash_select_seq (
	input  logic clk48m,
	input  logic rst,
	input  logic fsel_load_i,
	input  logic fsel_value_i,
	input  logic reload_arm_i,
	output logic fsel_d_o,
	output logic fsel_c_o,
	output logic programn_o
);
	import misc_regs_pkg::*;

	logic [$bits(FSEL_DELAY_START)-1:0] count_q;
	logic                               fsel_d_q;
	logic                               arm_q;
	logic                               reload_q;

	// ------------------------------------------------------------
	// select latch and down counter
	// ------------------------------------------------------------

	// the d flop muxing the two flashes is clocked mid-sequence,
	// reload is only pulled once the count has run out
	always_ff @(posedge clk48m) begin
		if (rst) begin
			count_q  <= '0;
			fsel_d_q <= 1'b0;
			arm_q    <= 1'b0;
			reload_q <= 1'b0;
		end else begin
			if (fsel_load_i) begin
				// a new load restarts the whole sequence
				count_q  <= FSEL_DELAY_START;
				fsel_d_q <= fsel_value_i;
				arm_q    <= reload_arm_i;
			end else if (count_q != '0) begin
				count_q <= count_q - 1'b1;
				if (count_q == 1 && arm_q) begin
					// sticky, only reset brings programn back up
					reload_q <= 1'b1;
				end
			end
		end
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------

	assign fsel_c_o   = (count_q <= FSEL_PULSE_HI) && (count_q >= FSEL_PULSE_LO);
	assign fsel_d_o   = fsel_d_q;
	assign programn_o = ~reload_q;

endmodule

// ==== logic/misc_regs.sv ====
`timescale 1ns/1ps

module misc_regs #(
	parameter int unsigned GENIO_W = 30,
	parameter int unsigned LED_W   = 9,
	parameter int unsigned BTN_W   = 8
) (
	input  logic               clk48m,
	input  logic               rst,
	misc_req_if.regs           req,
	input  logic [BTN_W-1:0]   btn_i,
	input  logic [GENIO_W-1:0] genio_in_i,
	output logic [LED_W-1:0]   led_o,
	output logic [GENIO_W-1:0] genio_out_o,
	output logic [GENIO_W-1:0] genio_oe_o,
	input  logic               fsel_d_i,
	output logic               fsel_load_o,
	output logic               fsel_value_o,
	output logic               reload_arm_o
);
	import soc_bus_pkg::*;
	import misc_regs_pkg::*;

	logic [LED_W-1:0]   led_q;
	logic [GENIO_W-1:0] genio_out_q;
	logic [GENIO_W-1:0] genio_oe_q;
	logic               fsel_value_q;
	logic               fsel_load_q;
	logic               reload_arm_q;
	logic [BTN_W-1:0]   btn_n;
	logic               wr;
	logic [GENIO_W-1:0] genio_wdata;

	assign wr          = req.req_valid && req.req_we;
	assign genio_wdata = req.req_wdata[GENIO_W-1:0];

	// ------------------------------------------------------------
	// register writes
	// ------------------------------------------------------------

	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_q        <= '0;
			genio_out_q  <= '0;
			genio_oe_q   <= '0;
			fsel_value_q <= 1'b0;
			fsel_load_q  <= 1'b0;
			reload_arm_q <= 1'b0;
		end else begin
			fsel_load_q <= 1'b0;
			if (wr) begin
				case (req.req_idx)
					REG_LED: begin
						led_q <= req.req_wdata[LED_W-1:0];
					end
					REG_GENIO_OUT: begin
						genio_out_q <= genio_wdata;
					end
					REG_GENIO_OE: begin
						genio_oe_q <= genio_wdata;
					end
					REG_GENIO_W2S: begin
						genio_out_q <= genio_out_q | genio_wdata;
					end
					REG_GENIO_W2C: begin
						genio_out_q <= genio_out_q & ~genio_wdata;
					end
					REG_FLASH_SEL: begin
						// value and arm go out with the load pulse
						fsel_value_q <= req.req_wdata[0];
						fsel_load_q  <= 1'b1;
						reload_arm_q <= (req.req_wdata[31:8] == RELOAD_KEY);
					end
					default: begin
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------
	// readback
	// ------------------------------------------------------------

	// buttons are active low on the board
	assign btn_n = ~btn_i;

	always_comb begin
		case (req.req_idx)
			REG_LED:       req.rdata = DATA_W'(led_q);
			REG_BTN:       req.rdata = DATA_W'(btn_n);
			REG_SOC_VER:   req.rdata = SOC_VERSION;
			// state as held by the sequencer, not the pending value
			REG_FLASH_SEL: req.rdata = DATA_W'(fsel_d_i);
			REG_GENIO_IN:  req.rdata = DATA_W'(genio_in_i);
			REG_GENIO_OUT: req.rdata = DATA_W'(genio_out_q);
			REG_GENIO_OE:  req.rdata = DATA_W'(genio_oe_q);
			default:       req.rdata = '0;
		endcase
	end

	assign led_o        = led_q;
	assign genio_out_o  = genio_out_q;
	assign genio_oe_o   = genio_oe_q;
	assign fsel_load_o  = fsel_load_q;
	assign fsel_value_o = fsel_value_q;
	assign reload_arm_o = reload_arm_q;

endmodule

// ==== logic/misc_regs_pkg.sv ====
package misc_regs_pkg;

	// ------------------------------------------------------------
	// misc register map, word index from address bits 6..2
	// ------------------------------------------------------------

	typedef enum logic [4:0] {
		REG_LED       = 5'd0,
		REG_BTN       = 5'd1,
		REG_SOC_VER   = 5'd2,
		REG_FLASH_SEL = 5'd13,
		REG_GENIO_IN  = 5'd17,
		REG_GENIO_OUT = 5'd18,
		REG_GENIO_OE  = 5'd19,
		// write-to-set and write-to-clear views of genio_out
		REG_GENIO_W2S = 5'd20,
		REG_GENIO_W2C = 5'd21
	} misc_reg_e;

	// fixed id word returned by REG_SOC_VER
	localparam logic [31:0] SOC_VERSION = 32'h0000_0000;

	// ------------------------------------------------------------
	// flash select and reload
	// ------------------------------------------------------------

	// upper 24 bits of a flash select write that also request reload
	localparam logic [23:0] RELOAD_KEY = 24'hD0F1A5;

	// sequencer counts down from the start value to zero
	localparam logic [2:0] FSEL_DELAY_START = 3'd7;

	// select clock is high for counts HI down to LO inclusive,
	// which leaves the d input settled before and after the edge
	localparam logic [2:0] FSEL_PULSE_HI = 3'd5;
	localparam logic [2:0] FSEL_PULSE_LO = 3'd3;

endpackage

// ==== logic/misc_req_if.sv ====
`timescale 1ns/1ps

interface misc_req_if;
	import soc_bus_pkg::*;
	import misc_regs_pkg::*;

	// one cycle per accepted misc request
	logic              req_valid;
	logic              req_we;
	misc_reg_e         req_idx;
	logic [DATA_W-1:0] req_wdata;

	// readback of req_idx, no register in the path
	logic [DATA_W-1:0] rdata;

	modport decoder (
		output req_valid,
		output req_we,
		output req_idx,
		output req_wdata,
		input  rdata
	);

	modport regs (
		input  req_valid,
		input  req_we,
		input  req_idx,
		input  req_wdata,
		output rdata
	);

endinterface

// ==== logic/soc_bus_pkg.sv ====
package soc_bus_pkg;

	// ------------------------------------------------------------
	// cpu bus geometry
	// ------------------------------------------------------------

	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 32;
	localparam int unsigned SEL_W  = DATA_W / 8;

	// ------------------------------------------------------------
	// address regions, top nibble of the bus address
	// ------------------------------------------------------------

	// only the misc region is served here, the rest is kept
	// so a decoded address still shows a readable name in waves
	typedef enum logic [3:0] {
		REGION_NULL         = 4'h0,
		REGION_UART         = 4'h1,
		REGION_MISC         = 4'h2,
		REGION_LCD          = 4'h3,
		REGION_RAM          = 4'h4,
		REGION_LINERENDERER = 4'h5,
		REGION_USB          = 4'h6,
		REGION_PIC          = 4'h7,
		REGION_AUDIO        = 4'h8,
		REGION_PSRAM        = 4'h9
	} bus_region_e;

	// ------------------------------------------------------------
	// bus error response
	// ------------------------------------------------------------

	// returned on any access outside the misc region
	localparam logic [DATA_W-1:0] BUS_ERROR_WORD = 32'hDEAD_BEEF;

endpackage

// ==== logic/soc_misc_ctrl.sv ====
`timescale 1ns/1ps

module soc_misc_ctrl #(
	parameter int unsigned GENIO_W = 30,
	parameter int unsigned LED_W   = 9,
	parameter int unsigned BTN_W   = 8
) (
	input  logic                           clk48m,
	input  logic                           rst,

	// wishbone classic slave
	input  logic                           wb_cyc_i,
	input  logic                           wb_stb_i,
	input  logic                           wb_we_i,
	input  logic [soc_bus_pkg::SEL_W-1:0]  wb_sel_i,
	input  logic [soc_bus_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [soc_bus_pkg::DATA_W-1:0] wb_dat_i,
	output logic [soc_bus_pkg::DATA_W-1:0] wb_dat_o,
	output logic                           wb_ack_o,

	// board io
	input  logic [BTN_W-1:0]               btn_i,
	input  logic [GENIO_W-1:0]             genio_in_i,
	output logic [LED_W-1:0]               led_o,
	output logic [GENIO_W-1:0]             genio_out_o,
	output logic [GENIO_W-1:0]             genio_oe_o,

	// flash select and fpga reload
	output logic                           fsel_d_o,
	output logic                           fsel_c_o,
	output logic                           programn_o,

	output logic                           irq_bus_error_o
);

	logic fsel_load;
	logic fsel_value;
	logic reload_arm;

	misc_req_if misc_req ();

	// ------------------------------------------------------------
	// decode, registers, flash select sequencer
	// ------------------------------------------------------------

	bus_decode u_bus_decode (
		.clk48m          (clk48m),
		.rst             (rst),
		.wb_cyc_i        (wb_cyc_i),
		.wb_stb_i        (wb_stb_i),
		.wb_we_i         (wb_we_i),
		.wb_sel_i        (wb_sel_i),
		.wb_adr_i        (wb_adr_i),
		.wb_dat_i        (wb_dat_i),
		.wb_dat_o        (wb_dat_o),
		.wb_ack_o        (wb_ack_o),
		.irq_bus_error_o (irq_bus_error_o),
		.req             (misc_req.decoder)
	);

	misc_regs #(
		.GENIO_W (GENIO_W),
		.LED_W   (LED_W),
		.BTN_W   (BTN_W)
	) u_misc_regs (
		.clk48m       (clk48m),
		.rst          (rst),
		.req          (misc_req.regs),
		.btn_i        (btn_i),
		.genio_in_i   (genio_in_i),
		.led_o        (led_o),
		.genio_out_o  (genio_out_o),
		.genio_oe_o   (genio_oe_o),
		.fsel_d_i     (fsel_d_o),
		.fsel_load_o  (fsel_load),
		.fsel_value_o (fsel_value),
		.reload_arm_o (reload_arm)
	);

	flash_select_seq u_flash_select_seq (
		.clk48m       (clk48m),
		.rst          (rst),
		.fsel_load_i  (fsel_load),
		.fsel_value_i (fsel_value),
		.reload_arm_i (reload_arm),
		.fsel_d_o     (fsel_d_o),
		.fsel_c_o     (fsel_c_o),
		.programn_o   (programn_o)
	);

endmodule

// ==== sim/soc_misc_ctrl_tb.sv ====
`timescale 1ns/1ps

module soc_misc_ctrl_tb;

	localparam int unsigned GENIO_W = 30;
	localparam int unsigned LED_W   = 9;
	localparam int unsigned BTN_W   = 8;

	// word indices of the misc register map
	localparam logic [4:0] IDX_LED  = 5'd0;
	localparam logic [4:0] IDX_BTN  = 5'd1;
	localparam logic [4:0] IDX_VER  = 5'd2;
	localparam logic [4:0] IDX_FSEL = 5'd13;
	localparam logic [4:0] IDX_GIN  = 5'd17;
	localparam logic [4:0] IDX_GOUT = 5'd18;
	localparam logic [4:0] IDX_GOE  = 5'd19;
	localparam logic [4:0] IDX_W2S  = 5'd20;
	localparam logic [4:0] IDX_W2C  = 5'd21;

	localparam logic [31:0] ERR_WORD   = 32'hDEAD_BEEF;
	localparam logic [23:0] KEY        = 24'hD0F1A5;
	localparam logic [31:0] LED_MASK   = 32'((64'd1 << LED_W) - 1);
	localparam logic [31:0] BTN_MASK   = 32'((64'd1 << BTN_W) - 1);
	localparam logic [31:0] GENIO_MASK = 32'((64'd1 << GENIO_W) - 1);
	localparam int unsigned WD_CYCLES_PER_TXN = 200;

	logic               clk48m;
	logic               rst;
	logic               wb_cyc_i;
	logic               wb_stb_i;
	logic               wb_we_i;
	logic [3:0]         wb_sel_i;
	logic [31:0]        wb_adr_i;
	logic [31:0]        wb_dat_i;
	logic [31:0]        wb_dat_o;
	logic               wb_ack_o;
	logic [BTN_W-1:0]   btn_i;
	logic [GENIO_W-1:0] genio_in_i;
	logic [LED_W-1:0]   led_o;
	logic [GENIO_W-1:0] genio_out_o;
	logic [GENIO_W-1:0] genio_oe_o;
	logic               fsel_d_o;
	logic               fsel_c_o;
	logic               programn_o;
	logic               irq_bus_error_o;

	// reference model of the writable registers
	logic [31:0] led_m;
	logic [31:0] gout_m;
	logic [31:0] goe_m;
	integer      seed;
	int unsigned txn_issued;

	soc_misc_ctrl #(
		.GENIO_W (GENIO_W),
		.LED_W   (LED_W),
		.BTN_W   (BTN_W)
	) DUT (.*);

	initial clk48m = 1'b0;
	always #5 clk48m = ~clk48m;

	// ------------------------------------------------------------
	// failure reporting and watchdog
	// ------------------------------------------------------------

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] t=%0t %s expected %h actual %h", $time, name, expected, actual);
		$display("Errors found");
		$fatal(1, "mismatch on %s", name);
	endtask

	task automatic report_failure(input string what);
		$display("[ERROR] t=%0t %s", $time, what);
		$display("Errors found");
		$fatal(1, "%s", what);
	endtask

	// budget grows by one share per transaction plus one share for reset
	initial begin : watchdog
		int unsigned cycles;
		cycles = 0;
		while (cycles < WD_CYCLES_PER_TXN * (txn_issued + 1)) begin
			@(posedge clk48m);
			cycles++;
		end
		$display("timeout: the bus or the sequencer stopped responding");
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	assert property (@(posedge clk48m) disable iff (rst)
		(wb_cyc_i && wb_stb_i && !wb_ack_o) |=> wb_ack_o)
	else report_failure("request not acked on the cycle after it was seen");

	assert property (@(posedge clk48m) disable iff (rst) wb_ack_o |=> !wb_ack_o)
	else report_failure("ack held for two cycles");

	assert property (@(posedge clk48m) disable iff (rst) wb_ack_o |-> (wb_cyc_i && wb_stb_i))
	else report_failure("ack without cyc and stb");

	assert property (@(posedge clk48m) disable iff (rst) irq_bus_error_o |-> wb_ack_o)
	else report_failure("bus error interrupt outside an ack cycle");

	// ------------------------------------------------------------
	// wishbone master
	// ------------------------------------------------------------

	function automatic logic [31:0] reg_addr(input logic [4:0] idx);
		return {4'h2, 21'd0, idx, 2'b00};
	endfunction

	// one classic cycle that returns just after the edge ending the ack cycle
	task automatic bus_access(input logic we, input logic [3:0] sel, input logic [31:0] adr,
		input logic [31:0] dat, output logic [31:0] rdat);
		int unsigned waited;
		logic        err_exp;
		waited  = 0;
		err_exp = (adr[31:28] != 4'h2);
		txn_issued++;
		@(posedge clk48m);
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		wb_we_i  <= we;
		wb_sel_i <= sel;
		wb_adr_i <= adr;
		wb_dat_i <= dat;
		do begin
			@(negedge clk48m);
			waited++;
		end while (!wb_ack_o);
		rdat = wb_dat_o;
		assert (waited == 2) else report_mismatch("ack latency", 32'd2, waited);
		assert (irq_bus_error_o == err_exp)
		else report_mismatch("irq_bus_error_o", err_exp, irq_bus_error_o);
		if (err_exp) begin
			assert (rdat == ERR_WORD) else report_mismatch("wb_dat_o", ERR_WORD, rdat);
		end
		@(posedge clk48m);
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		wb_we_i  <= 1'b0;
	endtask

	task automatic write_reg(input logic [4:0] idx, input logic [31:0] dat);
		logic [31:0] unused;
		bus_access(1'b1, 4'hF, reg_addr(idx), dat, unused);
	endtask

	task automatic read_reg(input logic [4:0] idx, input logic [31:0] expected,
		input string name);
		logic [31:0] rd;
		bus_access(1'b0, 4'hF, reg_addr(idx), 32'd0, rd);
		assert (rd == expected) else report_mismatch(name, expected, rd);
	endtask

	task automatic check_outputs();
		@(negedge clk48m);
		assert (32'(led_o) == led_m) else report_mismatch("led_o", led_m, 32'(led_o));
		assert (32'(genio_out_o) == gout_m)
		else report_mismatch("genio_out_o", gout_m, 32'(genio_out_o));
		assert (32'(genio_oe_o) == goe_m)
		else report_mismatch("genio_oe_o", goe_m, 32'(genio_oe_o));
	endtask

	task automatic apply_reset();
		rst <= 1'b1;
		repeat (5) @(posedge clk48m);
		rst <= 1'b0;
		led_m  = '0;
		gout_m = '0;
		goe_m  = '0;
		@(negedge clk48m);
		assert (!wb_ack_o && !irq_bus_error_o && !fsel_c_o && !fsel_d_o)
		else report_failure("ack, bus error irq, fsel_c_o or fsel_d_o high after reset");
		assert (programn_o) else report_failure("programn_o low after reset");
		check_outputs();
	endtask

	// counts the select clock pulse and checks that programn falls only after it
	task automatic watch_fsel(input logic armed);
		int unsigned k;
		int unsigned highs;
		int unsigned rises;
		int unsigned low_at;
		logic        prev_c;
		highs  = 0;
		rises  = 0;
		low_at = 0;
		prev_c = 1'b0;
		for (k = 1; k <= 12; k++) begin
			@(negedge clk48m);
			if (fsel_c_o && !prev_c)
				rises++;
			if (fsel_c_o)
				highs++;
			prev_c = fsel_c_o;
			if (!programn_o && low_at == 0) begin
				low_at = k;
				assert (highs == 3 && !fsel_c_o)
				else report_failure("programn_o fell before the fsel_c_o pulse ended");
			end
		end
		assert (highs == 3) else report_mismatch("fsel_c_o high cycles", 32'd3, highs);
		assert (rises == 1) else report_mismatch("fsel_c_o pulses", 32'd1, rises);
		// the 9th sample follows the 8th edge after the ack cycle
		if (armed) begin
			assert (low_at != 0 && low_at <= 9)
			else report_failure("programn_o not low within 8 cycles of the ack");
		end else begin
			assert (low_at == 0) else report_failure("programn_o fell without the reload key");
		end
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------

	initial begin : stimulus
		logic [31:0] d;
		logic [31:0] rd;
		int unsigned i;
		seed       = 30;
		txn_issued = 0;
		rst        = 1'b1;
		wb_cyc_i   = 1'b0;
		wb_stb_i   = 1'b0;
		wb_we_i    = 1'b0;
		wb_sel_i   = '0;
		wb_adr_i   = '0;
		wb_dat_i   = '0;
		btn_i      = '0;
		genio_in_i = '0;
		apply_reset();

		read_reg(IDX_VER, 32'd0, "version readback");
		d = $random(seed);
		write_reg(IDX_LED, d);
		led_m = d & LED_MASK;
		check_outputs();
		read_reg(IDX_LED, led_m, "led readback");

		// a write without byte lane 0 must not reach the register
		bus_access(1'b1, 4'hE, reg_addr(IDX_LED), ~led_m, rd);
		check_outputs();
		read_reg(IDX_LED, led_m, "led after a write without lane 0");

		d = $random(seed);
		write_reg(IDX_GOUT, d);
		gout_m = d & GENIO_MASK;
		check_outputs();
		read_reg(IDX_GOUT, gout_m, "genio_out readback");
		d = $random(seed);
		write_reg(IDX_GOE, d);
		goe_m = d & GENIO_MASK;
		check_outputs();
		read_reg(IDX_GOE, goe_m, "genio_oe readback");

		// buttons read back inverted and genio_in reads as driven
		d = $random(seed);
		@(posedge clk48m);
		btn_i      <= d[BTN_W-1:0];
		genio_in_i <= ~d[GENIO_W-1:0];
		read_reg(IDX_BTN, ~d & BTN_MASK, "button readback");
		read_reg(IDX_GIN, ~d & GENIO_MASK, "genio_in readback");
		read_reg(5'd7, 32'd0, "unmapped index readback");

		for (i = 0; i < 16; i++) begin
			d = $random(seed);
			if (d[31]) begin
				write_reg(IDX_W2S, d);
				gout_m = gout_m | (d & GENIO_MASK);
			end else begin
				write_reg(IDX_W2C, d);
				gout_m = gout_m & ~(d & GENIO_MASK);
			end
			check_outputs();
		end

		// writes to any region but misc must leave the registers alone
		for (i = 0; i < 16; i++) begin
			d = $random(seed);
			if (i != 2)
				bus_access(d[0], 4'hF, {i[3:0], d[27:0]}, d, rd);
		end
		check_outputs();

		write_reg(IDX_FSEL, 32'h0000_0001);
		watch_fsel(1'b0);
		assert (fsel_d_o) else report_mismatch("fsel_d_o", 32'd1, 32'(fsel_d_o));
		read_reg(IDX_FSEL, 32'd1, "flash select readback");

		write_reg(IDX_FSEL, {KEY, 8'h00});
		watch_fsel(1'b1);
		assert (!fsel_d_o) else report_mismatch("fsel_d_o", 32'd0, 32'(fsel_d_o));
		write_reg(IDX_FSEL, 32'h0000_0001);
		repeat (12) begin
			@(negedge clk48m);
			assert (!programn_o) else report_failure("programn_o rose again before reset");
		end
		@(posedge clk48m);
		apply_reset();

		$display("No errors");
		$finish;
	end

endmodule

// ==== soc_misc_ctrl.f ====
logic/soc_bus_pkg.sv
logic/misc_regs_pkg.sv
logic/misc_req_if.sv
logic/bus_decode.sv
logic/misc_regs.sv
logic/flash_select_seq.sv
logic/soc_misc_ctrl.sv
sim/soc_misc_ctrl_tb.sv
